// ==== surf5_cfg.svh ====
`ifndef SURF5_CFG_SVH
`define SURF5_CFG_SVH

// Control bus widths.
`define WBC_ADR_W 20
`define WBC_DAT_W 32
`define WBC_SEL_W 4

// Address split into region and word offset.
`define WBC_REGION_W 4
`define WBC_OFFSET_W 16

// Region codes.
`define WBC_REGION_ID 4'd0
`define WBC_REGION_MON 4'd1

// ID/control block offsets.
`define ID_OFS_VERSION 16'd0
`define ID_OFS_CONTROL 16'd1
`define ID_OFS_SCRATCH 16'd2

// Transaction monitor offsets.
`define MON_OFS_DATA 16'd0
`define MON_OFS_INFO 16'd1

// Firmware version fields, packed MSB first.
`define SURF5_BOARDREV 4'h1
`define SURF5_MONTH 4'd6
`define SURF5_DAY 8'd10
`define SURF5_MAJOR 4'd0
`define SURF5_MINOR 4'd2
`define SURF5_REVISION 8'd7

// sys_clk cycles per SST period.
`define SST_PHASES 4

`endif

// ==== surf5_pkg.sv ====
`include "surf5_cfg.svh"

package surf5_pkg;

	// One control bus address, seen two ways.
	// The raw view is what the monitor records.
	// The field view is what the cycle FSM decodes.
	typedef union packed {
		logic [`WBC_ADR_W-1:0] raw;
		struct packed {
			// Upper bits pick the slave region.
			logic [`WBC_REGION_W-1:0] region;
			// Word offset inside the region.
			logic [`WBC_OFFSET_W-1:0] offset;
		} f;
	} wbc_adr_u;

endpackage

// ==== wbc_cycle_fsm.sv ====
`timescale 1ns/100ps
`include "surf5_cfg.svh"

module wbc_cycle_fsm (
	input  logic                     sys_clk,
	input  logic                     rst_i,
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  surf5_pkg::wbc_adr_u      wb_adr_i,
	input  logic [`WBC_DAT_W-1:0]    wb_dat_i,
	input  logic [`WBC_SEL_W-1:0]    wb_sel_i,
	output logic                     wb_ack_o,
	output logic                     wb_err_o,
	output logic [`WBC_DAT_W-1:0]    wb_dat_o,
	output logic                     id_stb_o,
	output logic                     mon_stb_o,
	output logic [`WBC_OFFSET_W-1:0] offset_o,
	output logic                     we_o,
	output logic [`WBC_DAT_W-1:0]    wdat_o,
	output logic [`WBC_SEL_W-1:0]    sel_o,
	input  logic [`WBC_DAT_W-1:0]    id_rdat_i,
	input  logic [`WBC_DAT_W-1:0]    mon_rdat_i,
	output logic                     done_o,
	output surf5_pkg::wbc_adr_u      done_adr_o,
	output logic                     done_we_o,
	output logic                     done_err_o,
	output logic [`WBC_DAT_W-1:0]    done_wdat_o,
	output logic [`WBC_DAT_W-1:0]    done_rdat_o
);
	import surf5_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ACCESS = 2'd1;
	localparam logic [1:0] ST_REPLY = 2'd2;

	logic [1:0] state_q;
	wbc_adr_u adr_q;
	logic we_q;
	logic [`WBC_DAT_W-1:0] wdat_q;
	logic [`WBC_SEL_W-1:0] sel_q;
	logic hit_id;
	logic hit_mon;
	logic [`WBC_DAT_W-1:0] rdat_mux;

	// Region decode on the latched address.
	assign hit_id = (adr_q.f.region == `WBC_REGION_ID);
	assign hit_mon = (adr_q.f.region == `WBC_REGION_MON);

	// Read data select, unmapped regions give zero.
	always_comb begin
		rdat_mux = '0;
		if (hit_id)
			rdat_mux = id_rdat_i;
		else if (hit_mon)
			rdat_mux = mon_rdat_i;
	end

	// Control path.
	// REPLY spans two cycles: one to raise ack or err, one to drop it.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (wb_cyc_i && wb_stb_i)
						state_q <= ST_ACCESS;
				end
				ST_ACCESS: begin
					state_q <= ST_REPLY;
				end
				ST_REPLY: begin
					if (wb_ack_o || wb_err_o) begin
						wb_ack_o <= 1'b0;
						wb_err_o <= 1'b0;
						state_q <= ST_IDLE;
					end else begin
						wb_ack_o <= hit_id || hit_mon;
						wb_err_o <= !(hit_id || hit_mon);
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Request is latched while idle; read data at the end of ACCESS.
	always_ff @(posedge sys_clk) begin
		if (state_q == ST_IDLE) begin
			adr_q <= wb_adr_i;
			we_q <= wb_we_i;
			wdat_q <= wb_dat_i;
			sel_q <= wb_sel_i;
		end
		if (state_q == ST_ACCESS)
			wb_dat_o <= rdat_mux;
	end

	// Slave side.
	assign id_stb_o = (state_q == ST_ACCESS) && hit_id;
	assign mon_stb_o = (state_q == ST_ACCESS) && hit_mon;
	assign offset_o = adr_q.f.offset;
	assign we_o = we_q;
	assign wdat_o = wdat_q;
	assign sel_o = sel_q;

	// Completion record for the monitor, one pulse per transfer.
	assign done_o = wb_ack_o || wb_err_o;
	assign done_adr_o = adr_q;
	assign done_we_o = we_q;
	assign done_err_o = wb_err_o;
	assign done_wdat_o = wdat_q;
	assign done_rdat_o = wb_dat_o;

	// Exactly one termination kind per transfer.
	a_ack_err_excl: assert property (@(posedge sys_clk) disable iff (rst_i)
		!(wb_ack_o && wb_err_o));

	// Ack is a single-cycle pulse.
	a_ack_single: assert property (@(posedge sys_clk) disable iff (rst_i)
		wb_ack_o |=> !wb_ack_o);

endmodule

// ==== sst_phase_timer.sv ====
`timescale 1ns/100ps
`include "surf5_cfg.svh"

module sst_phase_timer (
	input  logic sys_clk,
	input  logic rst_i,
	output logic sst_flag_o,
	output logic sst_copy_o,
	output logic sync_o
);

	localparam int CNT_W = $clog2(`SST_PHASES);

	logic [CNT_W-1:0] phase_q;
	logic [1:0] flag_dly_q;

	// Free-running phase count, 0 first after reset.
	always_ff @(posedge sys_clk) begin
		if (rst_i)
			phase_q <= '0;
		else if (phase_q == CNT_W'(`SST_PHASES - 1))
			phase_q <= '0;
		else
			phase_q <= phase_q + 1'b1;
	end

	// First clock of the four in an SST period.
	assign sst_flag_o = (phase_q == '0);

	// Copy pulse set after the flag, cleared by the flag two cycles late.
	// Sync phase toggles once per period.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			flag_dly_q <= 2'b00;
			sst_copy_o <= 1'b0;
			sync_o <= 1'b0;
		end else begin
			flag_dly_q <= {flag_dly_q[0], sst_flag_o};
			if (sst_flag_o)
				sst_copy_o <= 1'b1;
			else if (flag_dly_q[1])
				sst_copy_o <= 1'b0;
			if (sst_flag_o)
				sync_o <= !sync_o;
		end
	end

	// Flag recurs exactly once per SST period.
	a_flag_period: assert property (@(posedge sys_clk) disable iff (rst_i)
		sst_flag_o |=> !sst_flag_o [*(`SST_PHASES - 1)] ##1 sst_flag_o);

endmodule

// ==== surf5_id_ctrl.sv ====
`timescale 1ns/100ps
`include "surf5_cfg.svh"

module surf5_id_ctrl (
	input  logic                     sys_clk,
	input  logic                     rst_i,
	input  logic                     stb_i,
	input  logic                     we_i,
	input  logic [`WBC_OFFSET_W-1:0] offset_i,
	input  logic [`WBC_DAT_W-1:0]    wdat_i,
	input  logic [`WBC_SEL_W-1:0]    sel_i,
	output logic [`WBC_DAT_W-1:0]    rdat_o,
	output logic                     clk_sel_o,
	output logic                     local_osc_en_o,
	output logic [3:0]               led_o,
	input  logic                     sst_flag_i
);

	// Read-only firmware version.
	localparam logic [31:0] VERSION = {`SURF5_BOARDREV, `SURF5_MONTH, `SURF5_DAY,
		`SURF5_MAJOR, `SURF5_MINOR, `SURF5_REVISION};

	logic clk_sel_q;
	logic osc_dis_q;
	logic [3:0] led_q;
	logic [`WBC_DAT_W-1:0] scratch_q;
	logic wr_ctrl;
	logic wr_scratch;

	assign wr_ctrl = stb_i && we_i && (offset_i == `ID_OFS_CONTROL);
	assign wr_scratch = stb_i && we_i && (offset_i == `ID_OFS_SCRATCH);

	// Control register, byte lane 0 only.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			clk_sel_q <= 1'b0;
			osc_dis_q <= 1'b0;
			led_q <= 4'h0;
		end else if (wr_ctrl && sel_i[0]) begin
			clk_sel_q <= wdat_i[0];
			osc_dis_q <= wdat_i[1];
			led_q <= wdat_i[7:4];
		end
	end

	// Scratch register, each lane on its own select.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			scratch_q <= '0;
		end else if (wr_scratch) begin
			for (int b = 0; b < `WBC_SEL_W; b++) begin
				if (sel_i[b])
					scratch_q[8*b +: 8] <= wdat_i[8*b +: 8];
			end
		end
	end

	// Readback, unused offsets and control bits read zero.
	always_comb begin
		rdat_o = '0;
		case (offset_i)
			`ID_OFS_VERSION: rdat_o = VERSION;
			`ID_OFS_CONTROL: rdat_o = {24'h0, led_q, 2'b00, osc_dis_q, clk_sel_q};
			`ID_OFS_SCRATCH: rdat_o = scratch_q;
			default: rdat_o = '0;
		endcase
	end

	assign clk_sel_o = clk_sel_q;
	// Oscillator enable is active high, register bit is a disable.
	assign local_osc_en_o = !osc_dis_q;
	// LEDs go dark on the flag cycle as an SST heartbeat.
	assign led_o = sst_flag_i ? 4'h0 : led_q;

endmodule

// ==== wbc_bus_monitor.sv ====
`timescale 1ns/100ps
`include "surf5_cfg.svh"

module wbc_bus_monitor (
	input  logic                     sys_clk,
	input  logic                     rst_i,
	input  logic                     done_i,
	input  surf5_pkg::wbc_adr_u      adr_i,
	input  logic                     we_i,
	input  logic                     err_i,
	input  logic [`WBC_DAT_W-1:0]    wdat_i,
	input  logic [`WBC_DAT_W-1:0]    rdat_i,
	input  logic [`WBC_OFFSET_W-1:0] offset_i,
	output logic [`WBC_DAT_W-1:0]    rdat_o
);

	localparam int PAD_W = `WBC_DAT_W - `WBC_ADR_W - 2;

	logic [`WBC_DAT_W-1:0] data_q;
	logic [`WBC_DAT_W-1:0] info_q;

	// Capture on completion.
	// Data word follows the direction of the transfer.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			data_q <= '0;
			info_q <= '0;
		end else if (done_i) begin
			data_q <= we_i ? wdat_i : rdat_i;
			// Info: err, we, then the raw address.
			info_q <= {{PAD_W{1'b0}}, err_i, we_i, adr_i.raw};
		end
	end

	// Readback.
	always_comb begin
		rdat_o = '0;
		case (offset_i)
			`MON_OFS_DATA: rdat_o = data_q;
			`MON_OFS_INFO: rdat_o = info_q;
			default: rdat_o = '0;
		endcase
	end

endmodule

// ==== surf5_ctrl_top.sv ====
`timescale 1ns/100ps
`include "surf5_cfg.svh"

module surf5_ctrl_top (
	input  logic                  sys_clk,
	input  logic                  rst_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  surf5_pkg::wbc_adr_u   wb_adr_i,
	input  logic [`WBC_DAT_W-1:0] wb_dat_i,
	input  logic [`WBC_SEL_W-1:0] wb_sel_i,
	output logic                  wb_ack_o,
	output logic                  wb_err_o,
	output logic [`WBC_DAT_W-1:0] wb_dat_o,
	output logic                  clk_sel_o,
	output logic                  local_osc_en_o,
	output logic [3:0]            led_o,
	output logic                  sst_copy_o,
	output logic                  sync_o
);
	import surf5_pkg::*;

	// Slave request side.
	logic id_stb;
	logic [`WBC_OFFSET_W-1:0] offset;
	logic we;
	logic [`WBC_DAT_W-1:0] wdat;
	logic [`WBC_SEL_W-1:0] sel;
	logic [`WBC_DAT_W-1:0] id_rdat;
	logic [`WBC_DAT_W-1:0] mon_rdat;
	// Completion record.
	logic done;
	wbc_adr_u done_adr;
	logic done_we;
	logic done_err;
	logic [`WBC_DAT_W-1:0] done_wdat;
	logic [`WBC_DAT_W-1:0] done_rdat;
	// First-of-four flag.
	logic sst_flag;

	wbc_cycle_fsm u_wbc_cycle_fsm (
		.sys_clk(sys_clk), .rst_i(rst_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_dat_o(wb_dat_o),
		.id_stb_o(id_stb), .mon_stb_o(), .offset_o(offset),
		.we_o(we), .wdat_o(wdat), .sel_o(sel),
		.id_rdat_i(id_rdat), .mon_rdat_i(mon_rdat),
		.done_o(done), .done_adr_o(done_adr), .done_we_o(done_we),
		.done_err_o(done_err), .done_wdat_o(done_wdat), .done_rdat_o(done_rdat));

	sst_phase_timer u_sst_phase_timer (
		.sys_clk(sys_clk), .rst_i(rst_i),
		.sst_flag_o(sst_flag), .sst_copy_o(sst_copy_o), .sync_o(sync_o));

	// Region 0.
	surf5_id_ctrl u_surf5_id_ctrl (
		.sys_clk(sys_clk), .rst_i(rst_i),
		.stb_i(id_stb), .we_i(we), .offset_i(offset), .wdat_i(wdat), .sel_i(sel),
		.rdat_o(id_rdat), .clk_sel_o(clk_sel_o), .local_osc_en_o(local_osc_en_o),
		.led_o(led_o), .sst_flag_i(sst_flag));

	// Region 1. Monitor reads need no strobe, only the offset.
	wbc_bus_monitor u_wbc_bus_monitor (
		.sys_clk(sys_clk), .rst_i(rst_i),
		.done_i(done), .adr_i(done_adr), .we_i(done_we), .err_i(done_err),
		.wdat_i(done_wdat), .rdat_i(done_rdat),
		.offset_i(offset), .rdat_o(mon_rdat));

endmodule

// ==== tb_surf5_ctrl.sv ====
`timescale 1ns/100ps
`include "surf5_cfg.svh"

module tb_surf5_ctrl;
	import surf5_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 2;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_RANDOM = 300;
	localparam int NUM_XFERS = NUM_RANDOM + 3;
	localparam int ACK_WAIT = 8;
	localparam int WATCHDOG_CYCLES = NUM_XFERS * 10 + RESET_CYCLES;

	logic sys_clk;
	logic rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	wbc_adr_u wb_adr_i;
	logic [`WBC_DAT_W-1:0] wb_dat_i;
	logic [`WBC_SEL_W-1:0] wb_sel_i;
	logic wb_ack_o;
	logic wb_err_o;
	logic [`WBC_DAT_W-1:0] wb_dat_o;
	logic clk_sel_o;
	logic local_osc_en_o;
	logic [3:0] led_o;
	logic sst_copy_o;
	logic sync_o;

	logic [15:0] lfsr_q;
	int value_errs;
	int proto_errs;
	// Reference model of the register and monitor state.
	logic m_clk_sel;
	logic m_osc_dis;
	logic [3:0] m_led;
	logic [31:0] m_scratch;
	logic [31:0] m_mon_data;
	logic [31:0] m_mon_info;
	logic [31:0] exp_version;

	surf5_ctrl_top i_surf5_ctrl_top (
		.sys_clk(sys_clk), .rst_i(rst_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_dat_o(wb_dat_o),
		.clk_sel_o(clk_sel_o), .local_osc_en_o(local_osc_en_o), .led_o(led_o),
		.sst_copy_o(sst_copy_o), .sync_o(sync_o));

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// 16-bit Fibonacci LFSR with taps 16 14 13 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One LFSR step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// True if v is some rotation of pat.
	function automatic logic is_rotation(input logic [7:0] v, input logic [7:0] pat);
		logic hit;
		hit = 1'b0;
		for (int r = 0; r < 8; r++) begin
			if (v == ((pat << r) | (pat >> (8 - r))))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// Expected read data from the model.
	function automatic logic [31:0] model_read(input logic [3:0] region, input logic [15:0] ofs);
		logic [31:0] v;
		v = '0;
		if (region == `WBC_REGION_ID) begin
			if (ofs == `ID_OFS_VERSION)
				v = exp_version;
			else if (ofs == `ID_OFS_CONTROL)
				v = {24'h0, m_led, 2'b00, m_osc_dis, m_clk_sel};
			else if (ofs == `ID_OFS_SCRATCH)
				v = m_scratch;
		end else if (region == `WBC_REGION_MON) begin
			if (ofs == `MON_OFS_DATA)
				v = m_mon_data;
			else if (ofs == `MON_OFS_INFO)
				v = m_mon_info;
		end
		return v;
	endfunction

	// Single transfer with stb held until ack or err and then dropped.
	task automatic bus_xfer(input logic we, input logic [3:0] region, input logic [15:0] ofs,
		input logic [31:0] dat, input logic [3:0] sel,
		output logic got_ack, output logic got_err, output logic [31:0] got_dat);
		int waited;
		@(posedge sys_clk);
		#DRIVE_DLY;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i.f.region = region;
		wb_adr_i.f.offset = ofs;
		wb_dat_i = dat;
		wb_sel_i = sel;
		got_ack = 1'b0;
		got_err = 1'b0;
		got_dat = '0;
		waited = 0;
		while (!(got_ack || got_err) && waited < ACK_WAIT) begin
			@(posedge sys_clk);
			#DRIVE_DLY;
			got_ack = wb_ack_o;
			got_err = wb_err_o;
			got_dat = wb_dat_o;
			waited++;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		assert (got_ack || got_err) else begin
			proto_errs++;
			$display("No ack or err came back within %0d cycles for region %0d offset %0d",
				ACK_WAIT, region, ofs);
		end
	endtask

	// Over one SST period the LEDs go dark exactly once.
	task automatic check_led_window();
		int lit;
		int dark;
		lit = 0;
		dark = 0;
		repeat (`SST_PHASES) begin
			@(posedge sys_clk);
			#DRIVE_DLY;
			if (led_o == m_led)
				lit++;
			else if (led_o == 4'h0)
				dark++;
		end
		assert (lit == `SST_PHASES - 1 && dark == 1) else begin
			value_errs++;
			$display("[FAIL] %0t: led_o lit %0d dark %0d for leds %h", $time, lit, dark, m_led);
		end
	endtask

	// Transfer, compare with the model, then advance the model.
	task automatic run_xfer(input logic we, input logic [3:0] region, input logic [15:0] ofs,
		input logic [31:0] dat, input logic [3:0] sel);
		logic ack;
		logic err;
		logic mapped;
		logic [31:0] rd;
		logic [31:0] exp_rd;
		exp_rd = model_read(region, ofs);
		mapped = (region == `WBC_REGION_ID) || (region == `WBC_REGION_MON);
		bus_xfer(we, region, ofs, dat, sel, ack, err, rd);
		if (ack || err) begin
			assert (ack == mapped && err == !mapped) else begin
				value_errs++;
				$display("[FAIL] %0t: region %0d ended ack=%0b err=%0b", $time, region, ack, err);
			end
			if (!we && mapped)
				assert (rd == exp_rd) else begin
					value_errs++;
					$display("[FAIL] %0t: read r%0d o%0d got %h exp %h",
						$time, region, ofs, rd, exp_rd);
				end
			if (we && mapped && region == `WBC_REGION_ID) begin
				if (ofs == `ID_OFS_CONTROL && sel[0]) begin
					m_clk_sel = dat[0];
					m_osc_dis = dat[1];
					m_led = dat[7:4];
				end
				if (ofs == `ID_OFS_SCRATCH)
					for (int b = 0; b < `WBC_SEL_W; b++)
						if (sel[b])
							m_scratch[8*b +: 8] = dat[8*b +: 8];
			end
			// Err reads return no slave data.
			m_mon_data = we ? dat : (mapped ? exp_rd : 32'h0);
			m_mon_info = {10'h0, !mapped, we, region, ofs};
			if (we && mapped && region == `WBC_REGION_ID && ofs == `ID_OFS_CONTROL) begin
				assert (clk_sel_o == m_clk_sel && local_osc_en_o == !m_osc_dis) else begin
					value_errs++;
					$display("[FAIL] %0t: clk_sel_o %0b osc_en %0b after control write",
						$time, clk_sel_o, local_osc_en_o);
				end
				if (m_led != 4'h0)
					check_led_window();
			end
		end
	endtask

	// Copy pulse and sync phase sampled every cycle after reset.
	initial begin
		logic [7:0] copy_hist;
		logic [7:0] sync_hist;
		int filled;
		copy_hist = '0;
		sync_hist = '0;
		filled = 0;
		@(negedge rst_i);
		forever begin
			@(posedge sys_clk);
			#DRIVE_DLY;
			copy_hist = {copy_hist[6:0], sst_copy_o};
			sync_hist = {sync_hist[6:0], sync_o};
			filled++;
			if (filled >= 8) begin
				assert (is_rotation(copy_hist, 8'b0011_0011)) else begin
					value_errs++;
					$display("[FAIL] %0t: sst_copy_o history %b", $time, copy_hist);
				end
				assert (is_rotation(sync_hist, 8'b0000_1111)) else begin
					value_errs++;
					$display("[FAIL] %0t: sync_o history %b", $time, sync_hist);
				end
			end
		end
	end

	// Watchdog.
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
		$display("test failed");
		$finish;
	end

	initial begin
		logic [1:0] kind;
		logic [3:0] region;
		logic [15:0] ofs;
		logic we;
		logic [3:0] sel;
		logic [31:0] dat;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		lfsr_q = 16'd92;
		value_errs = 0;
		proto_errs = 0;
		m_clk_sel = 1'b0;
		m_osc_dis = 1'b0;
		m_led = 4'h0;
		m_scratch = '0;
		m_mon_data = '0;
		m_mon_info = '0;
		exp_version = {`SURF5_BOARDREV, `SURF5_MONTH, `SURF5_DAY,
			`SURF5_MAJOR, `SURF5_MINOR, `SURF5_REVISION};
		rst_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#DRIVE_DLY;
		rst_i = 1'b0;
		// Reset values.
		assert (local_osc_en_o == 1'b1) else begin
			value_errs++;
			$display("[FAIL] %0t: local_osc_en_o low after reset", $time);
		end
		run_xfer(1'b0, `WBC_REGION_ID, `ID_OFS_VERSION, 32'h0, 4'hf);
		run_xfer(1'b0, `WBC_REGION_ID, `ID_OFS_CONTROL, 32'h0, 4'hf);
		run_xfer(1'b0, `WBC_REGION_ID, `ID_OFS_SCRATCH, 32'h0, 4'hf);
		// Random mix over all regions.
		for (int i = 0; i < NUM_RANDOM; i++) begin
			kind = 2'(rand_bits(2));
			if (kind == 2'd3) begin
				region = 4'(rand_bits(4));
				if (region < 4'd2)
					region = region + 4'd2;
			end else begin
				region = (kind == 2'd2) ? `WBC_REGION_MON : `WBC_REGION_ID;
			end
			ofs = 16'(rand_bits(2));
			we = 1'(rand_bits(1));
			sel = 4'(rand_bits(4));
			dat = rand_bits(32);
			run_xfer(we, region, ofs, dat, sel);
		end
		repeat (2) @(posedge sys_clk);
		$display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
surf5_pkg.sv
wbc_cycle_fsm.sv
sst_phase_timer.sv
surf5_id_ctrl.sv
wbc_bus_monitor.sv
surf5_ctrl_top.sv
tb_surf5_ctrl.sv

// ==== Bender.yml ====
package:
  name: surf5_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - surf5_pkg.sv
      - wbc_cycle_fsm.sv
      - sst_phase_timer.sv
      - surf5_id_ctrl.sv
      - wbc_bus_monitor.sv
      - surf5_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_surf5_ctrl.sv
